// ==== files.f ====
src/lfsr_pkg.sv
src/tx_lane_pkg.sv
src/lfsr_lane_gen.sv
src/training_seq_ctrl.sv
src/lane_mapper.sv
src/lfsr_transmitter.sv
dv/tb_lfsr_transmitter.sv

// ==== Bender.yml ====
package:
  name: lfsr_transmitter

sources:
  - src/lfsr_pkg.sv
  - src/tx_lane_pkg.sv
  - src/lfsr_lane_gen.sv
  - src/training_seq_ctrl.sv
  - src/lane_mapper.sv
  - src/lfsr_transmitter.sv
  - target: test
    files:
      - dv/tb_lfsr_transmitter.sv

// ==== dv/tb_lfsr_transmitter.sv ====
`timescale 1ns/1ps

module tb_lfsr_transmitter;

    import lfsr_pkg::*;
    import tx_lane_pkg::*;

    localparam int N_ROWS = 20;

    logic         i_clk;
    logic         i_rst_n;
    train_state_e i_state;
    lane_map_e    i_lane_map;
    logic         i_enable_reversal;
    lane_bus_t    o_lane_data;
    logic         o_tx_done;
    logic         o_enable_frame;

    // Stimulus table
    train_state_e row_state  [N_ROWS];
    lane_map_e    row_map    [N_ROWS];
    logic         row_rev    [N_ROWS];
    int           row_cycles [N_ROWS];
    string        row_name   [N_ROWS];

    // Reference model state
    logic [LFSR_STATE_W-1:0] m_state [N_GEN];
    logic [LFSR_EXT_W-1:0]   m_ext   [N_GEN];
    int                      m_pat;
    int                      m_id;
    logic                    m_rev;
    logic                    m_done;
    logic                    m_frame;
    logic                    m_fresh;      // Generators still hold their seeds
    lane_bus_t               exp_lane;
    lane_bus_t               seed_lane;
    logic                    seed_due;
    logic                    halves_due;

    int          row_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;
    int          timeout_limit;
    logic [31:0] lfsr_q;

    lfsr_transmitter UUT (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_state           (i_state),
        .i_lane_map        (i_lane_map),
        .i_enable_reversal (i_enable_reversal),
        .o_lane_data       (o_lane_data),
        .o_tx_done         (o_tx_done),
        .o_enable_frame    (o_enable_frame)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: the run went past %0d clock cycles", timeout_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic lane_active(input lane_map_e lmap, input int j);
        case (lmap)
            MAP_LO8:   return j < 8;
            MAP_HI8:   return j >= 8;
            MAP_ALL16: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic lane_word_t lane_id_word(input int k);
        logic [15:0] half;
        half = {LANE_ID_MARK, 8'(k), LANE_ID_MARK};
        return {half, half};
    endfunction

    task automatic set_row(input int idx, input train_state_e st, input lane_map_e lmap,
                           input logic rev, input int cycles, input string name);
        row_state[idx]  = st;
        row_map[idx]    = lmap;
        row_rev[idx]    = rev;
        row_cycles[idx] = cycles;
        row_name[idx]   = name;
    endtask

    task automatic swap_rows(input int a, input int b);
        train_state_e st;
        lane_map_e    lmap;
        logic         rev;
        int           cycles;
        string        name;
        st     = row_state[a];
        lmap   = row_map[a];
        rev    = row_rev[a];
        cycles = row_cycles[a];
        name   = row_name[a];
        set_row(a, row_state[b], row_map[b], row_rev[b], row_cycles[b], row_name[b]);
        set_row(b, st, lmap, rev, cycles, name);
    endtask

    task automatic init_model();
        for (int g = 0; g < N_GEN; g++) begin
            m_state[g] = LFSR_SEED[g];
            m_ext[g]   = '0;
        end
        m_pat      = 0;
        m_id       = 0;
        m_rev      = 1'b0;
        m_done     = 1'b0;
        m_frame    = 1'b0;
        m_fresh    = 1'b1;
        exp_lane   = '0;
        seed_lane  = '0;
        seed_due   = 1'b0;
        halves_due = 1'b0;
    endtask

    // One rising edge of the reference model, from the inputs sampled at that edge
    task automatic model_step(input train_state_e st, input lane_map_e lmap, input logic rev_in);
        lane_word_t words [N_GEN];
        lane_word_t nxt;
        logic       emit;
        logic       mirror;
        int         src;
        for (int g = 0; g < N_GEN; g++) begin
            words[g] = {m_ext[g], m_state[g]};
        end
        emit = ((st == ST_PATTERN) && (m_pat != PATTERN_BURST_LEN - 1)) ||
               ((st == ST_LANE_ID) && (m_id != ID_BURST_LEN - 1));
        mirror     = m_rev && (lmap == MAP_ALL16);
        seed_due   = emit && (st == ST_PATTERN) && m_fresh;
        halves_due = (st == ST_PATTERN) && (lmap == MAP_ALL16);
        for (int j = 0; j < N_LANES; j++) begin
            exp_lane[j]  = '0;
            seed_lane[j] = '0;
            if (emit && lane_active(lmap, j)) begin
                if (st == ST_LANE_ID) begin
                    exp_lane[j] = lane_id_word(mirror ? N_LANES - 1 - j : j);
                end else begin
                    src          = mirror ? (N_GEN - 1 - (j % N_GEN)) : (j % N_GEN);
                    exp_lane[j]  = words[src];
                    seed_lane[j] = lane_word_t'(LFSR_SEED[src]);   // Top bits zero
                end
            end
        end
        case (st)
            ST_IDLE: begin
                m_pat   = 0;
                m_id    = 0;
                m_frame = 1'b0;
                m_done  = rev_in && (lmap == MAP_ALL16);
                if (m_done) begin
                    m_rev = 1'b1;
                end
            end
            ST_CLEAR: begin
                m_done  = 1'b1;
                m_rev   = 1'b0;
                m_fresh = 1'b1;
                for (int g = 0; g < N_GEN; g++) begin
                    m_state[g] = LFSR_SEED[g];
                    m_ext[g]   = '0;
                end
            end
            ST_PATTERN: begin
                m_done  = (m_pat == PATTERN_BURST_LEN - 1);
                m_frame = !m_done;
                m_pat   = (m_pat + 1) % PATTERN_BURST_LEN;
                m_fresh = 1'b0;
                for (int g = 0; g < N_GEN; g++) begin
                    nxt        = lfsr_next(m_state[g]);
                    m_ext[g]   = nxt[LANE_WORD_W-1:LFSR_STATE_W];
                    m_state[g] = nxt[LFSR_STATE_W-1:0];
                end
            end
            default: begin
                m_done  = (m_id == ID_BURST_LEN - 1);
                m_frame = !m_done;
                m_id    = (m_id + 1) % ID_BURST_LEN;
            end
        endcase
    endtask

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0.1f ns: %s", $realtime, msg);
        row_errors   = row_errors + 1;
        total_errors = total_errors + 1;
    endtask

    task automatic check_outputs();
        int bad;
        bad = -1;
        if (o_tx_done !== m_done) begin
            report_error($sformatf("o_tx_done is %b, expected %b", o_tx_done, m_done));
        end
        if (o_enable_frame !== m_frame) begin
            report_error($sformatf("o_enable_frame is %b, expected %b", o_enable_frame, m_frame));
        end
        for (int j = N_LANES - 1; j >= 0; j--) begin
            if (o_lane_data[j] !== exp_lane[j]) begin
                bad = j;
            end
        end
        if (bad >= 0) begin
            report_error($sformatf("lane %0d is %h, expected %h",
                                   bad, o_lane_data[bad], exp_lane[bad]));
        end
        if (seed_due) begin
            for (int j = 0; j < N_LANES; j++) begin
                if (o_lane_data[j] !== seed_lane[j]) begin
                    report_error($sformatf("first word on lane %0d is %h, seed gives %h",
                                           j, o_lane_data[j], seed_lane[j]));
                end
            end
        end
        if (halves_due) begin
            for (int j = 0; j < 8; j++) begin
                if (o_lane_data[j] !== o_lane_data[j+8]) begin
                    report_error($sformatf("lane %0d differs from lane %0d", j, j + 8));
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (row_errors == 0) begin
            $display("test %-24s ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %-24s failed with %0d errors", name, row_errors);
        end
        row_errors = 0;
    endtask

    initial begin
        i_clk             = 1'b0;
        i_rst_n           = 1'b0;
        i_state           = ST_IDLE;
        i_lane_map        = MAP_NONE;
        i_enable_reversal = 1'b0;
        row_errors        = 0;
        total_errors      = 0;
        tests_run         = 0;
        tests_failed      = 0;
        cycle_cnt         = 0;

        set_row(0,  ST_CLEAR,   MAP_LO8,   1'b0, 2,   "clear after reset");
        set_row(1,  ST_PATTERN, MAP_LO8,   1'b0, 128, "pattern lo8");
        set_row(2,  ST_PATTERN, MAP_HI8,   1'b0, 128, "pattern hi8");
        set_row(3,  ST_IDLE,    MAP_HI8,   1'b1, 3,   "idle, reversal on hi8");
        set_row(4,  ST_CLEAR,   MAP_ALL16, 1'b0, 1,   "clear");
        set_row(5,  ST_PATTERN, MAP_ALL16, 1'b0, 130, "pattern all16");
        set_row(6,  ST_LANE_ID, MAP_LO8,   1'b0, 64,  "lane id lo8");
        set_row(7,  ST_LANE_ID, MAP_HI8,   1'b0, 64,  "lane id hi8");
        set_row(8,  ST_LANE_ID, MAP_ALL16, 1'b0, 130, "lane id all16");
        set_row(9,  ST_LANE_ID, MAP_NONE,  1'b0, 10,  "lane id none");
        set_row(10, ST_IDLE,    MAP_ALL16, 1'b1, 3,   "reversal request");
        set_row(11, ST_PATTERN, MAP_ALL16, 1'b0, 128, "reversed pattern");
        set_row(12, ST_LANE_ID, MAP_ALL16, 1'b0, 64,  "reversed lane id");
        set_row(13, ST_IDLE,    MAP_ALL16, 1'b0, 2,   "idle keeps reversal");
        set_row(14, ST_LANE_ID, MAP_ALL16, 1'b0, 10,  "lane id still reversed");
        set_row(15, ST_LANE_ID, MAP_HI8,   1'b0, 10,  "lane id hi8 not mirrored");
        set_row(16, ST_CLEAR,   MAP_ALL16, 1'b0, 2,   "clear drops reversal");
        set_row(17, ST_PATTERN, MAP_ALL16, 1'b0, 20,  "normal pattern");
        set_row(18, ST_LANE_ID, MAP_ALL16, 1'b0, 20,  "normal lane id");
        set_row(19, ST_IDLE,    MAP_NONE,  1'b0, 4,   "final idle");

        // One random bit picks which mirrored burst comes first
        lfsr_q = lfsr_step(32'h81d2_ac27);
        if (lfsr_q[0]) begin
            swap_rows(11, 12);
        end

        timeout_limit = 50;
        for (int r = 0; r < N_ROWS; r++) begin
            timeout_limit = timeout_limit + row_cycles[r];
        end

        init_model();
        repeat (3) @(posedge i_clk);
        #0.5;
        i_rst_n = 1'b1;
        check_outputs();
        end_test("reset");

        for (int r = 0; r < N_ROWS; r++) begin
            for (int c = 0; c < row_cycles[r]; c++) begin
                i_state           = row_state[r];
                i_lane_map        = row_map[r];
                i_enable_reversal = row_rev[r];
                @(posedge i_clk);
                model_step(i_state, i_lane_map, i_enable_reversal);
                #0.5;
                check_outputs();
            end
            end_test(row_name[r]);
        end

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== src/lfsr_transmitter.sv ====
`timescale 1ns/1ps

module lfsr_transmitter (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  tx_lane_pkg::train_state_e i_state,
    input  tx_lane_pkg::lane_map_e    i_lane_map,
    input  logic                      i_enable_reversal,
    output tx_lane_pkg::lane_bus_t    o_lane_data,
    output logic                      o_tx_done,
    output logic                      o_enable_frame
);

    import lfsr_pkg::*;

    logic                   gen_clear;
    logic                   gen_advance;
    logic                   emit;
    logic                   emit_id;
    logic                   reversed;
    lane_word_t [N_GEN-1:0] gen_words;

    training_seq_ctrl u_ctrl (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_state           (i_state),
        .i_lane_map        (i_lane_map),
        .i_enable_reversal (i_enable_reversal),
        .o_gen_clear       (gen_clear),
        .o_gen_advance     (gen_advance),
        .o_emit            (emit),
        .o_emit_id         (emit_id),
        .o_reversed        (reversed),
        .o_tx_done         (o_tx_done),
        .o_enable_frame    (o_enable_frame)
    );

    // One generator per lane of a half; each has its own seed
    for (genvar g = 0; g < N_GEN; g++) begin : g_gen
        lfsr_lane_gen u_gen (
            .i_clk     (i_clk),
            .i_rst_n   (i_rst_n),
            .i_clear   (gen_clear),
            .i_advance (gen_advance),
            .i_seed    (LFSR_SEED[g]),
            .o_word    (gen_words[g])
        );
    end

    lane_mapper u_mapper (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lane_map  (i_lane_map),
        .i_emit      (emit),
        .i_emit_id   (emit_id),
        .i_reversed  (reversed),
        .i_gen_words (gen_words),
        .o_lane_data (o_lane_data)
    );

endmodule

// ==== src/lane_mapper.sv ====
`timescale 1ns/1ps

module lane_mapper (
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  tx_lane_pkg::lane_map_e                   i_lane_map,
    input  logic                                     i_emit,
    input  logic                                     i_emit_id,
    input  logic                                     i_reversed,
    input  lfsr_pkg::lane_word_t [lfsr_pkg::N_GEN-1:0] i_gen_words,
    output tx_lane_pkg::lane_bus_t                   o_lane_data
);

    import lfsr_pkg::*;
    import tx_lane_pkg::*;

    lane_bus_t          id_words;
    lane_bus_t          lane_d;
    lane_bus_t          lane_q;
    logic [N_LANES-1:0] lane_on;
    logic               rev_all;

    // Fixed lane identifiers, one per physical lane
    for (genvar j = 0; j < N_LANES; j++) begin : g_lane_id
        assign id_words[j] = {2{LANE_ID_MARK, LANE_IDX_W'(j), LANE_ID_MARK}};
    end

    always_comb begin
        case (i_lane_map)
            MAP_LO8:   lane_on = 16'h00FF;
            MAP_HI8:   lane_on = 16'hFF00;
            MAP_ALL16: lane_on = 16'hFFFF;
            default:   lane_on = 16'h0000;
        endcase
    end

    assign rev_all = i_reversed && (i_lane_map == MAP_ALL16);

    // Both halves reuse generators 0..7; reversal mirrors the lane order
    always_comb begin
        lane_d = '0;
        for (int j = 0; j < N_LANES; j++) begin
            if (i_emit && lane_on[j]) begin
                if (i_emit_id) begin
                    lane_d[j] = id_words[rev_all ? (N_LANES - 1 - j) : j];
                end else begin
                    lane_d[j] = i_gen_words[rev_all ? (N_GEN - 1 - (j % N_GEN)) : (j % N_GEN)];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lane_q <= '0;
        end else begin
            lane_q <= lane_d;   // Zero unless a word is emitted this cycle
        end
    end

    assign o_lane_data = lane_q;

endmodule

// ==== src/training_seq_ctrl.sv ====
`timescale 1ns/1ps

module training_seq_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  tx_lane_pkg::train_state_e i_state,
    input  tx_lane_pkg::lane_map_e   i_lane_map,
    input  logic                     i_enable_reversal,
    output logic                     o_gen_clear,
    output logic                     o_gen_advance,
    output logic                     o_emit,
    output logic                     o_emit_id,
    output logic                     o_reversed,
    output logic                     o_tx_done,
    output logic                     o_enable_frame
);

    import tx_lane_pkg::*;

    logic [PAT_CNT_W-1:0] pat_cnt_q;
    logic [ID_CNT_W-1:0]  id_cnt_q;
    logic                 pat_last;
    logic                 id_last;
    logic                 rev_req;
    logic                 rev_q;
    logic                 done_q;
    logic                 frame_q;

    // Last count of each period is the gap cycle
    assign pat_last = (pat_cnt_q == PAT_CNT_W'(PATTERN_BURST_LEN - 1));
    assign id_last  = (id_cnt_q == ID_CNT_W'(ID_BURST_LEN - 1));

    // Reversal is only meaningful with all 16 lanes up
    assign rev_req = i_enable_reversal && (i_lane_map == MAP_ALL16);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pat_cnt_q <= '0;
            id_cnt_q  <= '0;
            rev_q     <= 1'b0;
            done_q    <= 1'b0;
            frame_q   <= 1'b0;
        end else begin
            case (i_state)
                ST_IDLE: begin
                    pat_cnt_q <= '0;
                    id_cnt_q  <= '0;
                    frame_q   <= 1'b0;
                    done_q    <= rev_req;   // Acknowledges the reversal request
                    if (rev_req) begin
                        rev_q <= 1'b1;
                    end
                end
                ST_CLEAR: begin
                    done_q <= 1'b1;
                    rev_q  <= 1'b0;  // Back to normal lane order
                end
                ST_PATTERN: begin
                    pat_cnt_q <= pat_last ? '0 : pat_cnt_q + 1'b1;
                    done_q    <= pat_last;
                    frame_q   <= !pat_last;
                end
                ST_LANE_ID: begin
                    id_cnt_q <= id_last ? '0 : id_cnt_q + 1'b1;
                    done_q   <= id_last;
                    frame_q  <= !id_last;
                end
                default: begin
                    done_q <= 1'b0;
                end
            endcase
        end
    end

    assign o_gen_clear   = (i_state == ST_CLEAR);
    assign o_gen_advance = (i_state == ST_PATTERN);   // Runs through the gap cycle too

    assign o_emit    = ((i_state == ST_PATTERN) && !pat_last) ||
                       ((i_state == ST_LANE_ID) && !id_last);
    assign o_emit_id = (i_state == ST_LANE_ID);

    assign o_reversed     = rev_q;
    assign o_tx_done      = done_q;
    assign o_enable_frame = frame_q;

endmodule

// ==== src/lfsr_lane_gen.sv ====
`timescale 1ns/1ps

module lfsr_lane_gen (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_clear,
    input  logic                              i_advance,
    input  logic [lfsr_pkg::LFSR_STATE_W-1:0] i_seed,
    output lfsr_pkg::lane_word_t              o_word
);

    import lfsr_pkg::*;

    logic [LFSR_STATE_W-1:0] state_q;
    logic [LFSR_EXT_W-1:0]   ext_q;   // Upper word bits from the last step

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= i_seed;
            ext_q   <= '0;
        end else if (i_clear) begin
            state_q <= i_seed;
            ext_q   <= '0;
        end else if (i_advance) begin
            {ext_q, state_q} <= lfsr_next(state_q);
        end
    end

    assign o_word = {ext_q, state_q};

endmodule

// ==== src/tx_lane_pkg.sv ====
package tx_lane_pkg;

    // Training step requested by the link FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_CLEAR   = 2'b01,
        ST_PATTERN = 2'b10,
        ST_LANE_ID = 2'b11
    } train_state_e;

    // Which lanes are functional
    typedef enum logic [1:0] {
        MAP_NONE  = 2'b00,
        MAP_LO8   = 2'b01,  // Lanes 0..7
        MAP_HI8   = 2'b10,  // Lanes 8..15
        MAP_ALL16 = 2'b11
    } lane_map_e;

    localparam int N_LANES = 16;

    // Burst period includes the trailing gap cycle
    localparam int PATTERN_BURST_LEN = 128;
    localparam int ID_BURST_LEN      = 64;
    localparam int PAT_CNT_W         = $clog2(PATTERN_BURST_LEN);
    localparam int ID_CNT_W          = $clog2(ID_BURST_LEN);

    // Lane ID is marker, 8-bit lane number, marker; sent twice per word
    localparam logic [3:0] LANE_ID_MARK = 4'b1010;
    localparam int         LANE_IDX_W   = 8;

    typedef lfsr_pkg::lane_word_t [N_LANES-1:0] lane_bus_t;

endpackage

// ==== src/lfsr_pkg.sv ====
package lfsr_pkg;

    localparam int LFSR_STATE_W = 23;
    localparam int LANE_WORD_W  = 32;
    localparam int LFSR_EXT_W   = LANE_WORD_W - LFSR_STATE_W;  // 9 bits above the state
    localparam int N_GEN        = 8;

    typedef logic [LANE_WORD_W-1:0] lane_word_t;

    // Power-up and clear values, generator 0 first
    localparam logic [LFSR_STATE_W-1:0] LFSR_SEED [N_GEN] = '{
        23'h1DBFBC,
        23'h0607BB,
        23'h1EC760,
        23'h18C0DB,
        23'h010F12,
        23'h19CFC9,
        23'h0277CE,
        23'h1BB807
    };

    // Output bit b is the parity of the state bits selected by LFSR_TAPS[b]
    localparam logic [LFSR_STATE_W-1:0] LFSR_TAPS [LANE_WORD_W] = '{
        23'h5EC59E,  // bit 0
        23'h1C8A19,
        23'h391432,
        23'h722864,
        23'h4551ED,
        23'h2BA2FF,
        23'h5745FE,
        23'h0F8AD9,
        23'h1F15B2,  // bit 8
        23'h3E2B64,
        23'h7C56C8,
        23'h59ACB5,
        23'h12584F,
        23'h24B09E,
        23'h49613C,
        23'h33C35D,
        23'h6786BA,  // bit 16
        23'h6E0C51,
        23'h7D1987,
        23'h5B322B,
        23'h176573,
        23'h2ECAE6,
        23'h5D95CC,
        23'h1A2ABD,
        23'h34557A,  // bit 24
        23'h68AAF4,
        23'h7054CD,
        23'h41A8BF,
        23'h22505B,
        23'h44A0B6,
        23'h284049,
        23'h508092
    };

    // 32 bits of LFSR output per step; the low 23 become the next state
    function automatic lane_word_t lfsr_next(input logic [LFSR_STATE_W-1:0] state);
        lane_word_t word;
        for (int b = 0; b < LANE_WORD_W; b++) begin
            word[b] = ^(state & LFSR_TAPS[b]);
        end
        return word;
    endfunction

endpackage
